// ==== rtl/fmau_pkg.sv ====
// Shared widths, flag positions, types and latency-class constants for the MAC unit.
package fmau_pkg;

  // Operand and result width.
  localparam int unsigned DATA_W = 64;
  // Lane width for single and simd operations.
  localparam int unsigned HALF_W = 32;
  // Default tag width.
  localparam int unsigned TAG_W_DEF = 4;

  // Bit positions inside the instruction flags.
  localparam int unsigned OP_MAC  = 2;
  localparam int unsigned OP_DBL  = 1;
  localparam int unsigned OP_SIMD = 0;

  // Bit positions inside the special class.
  localparam int unsigned SPEC_A_ZERO = 0;
  localparam int unsigned SPEC_B_ZERO = 1;

  // Finish-slot distances, counted from EX1.
  localparam int unsigned LAT_EX3 = 3;
  localparam int unsigned LAT_EX4 = 4;
  localparam int unsigned LAT_EX5 = 5;

  // Operand or result word.
  typedef logic [DATA_W-1:0] fmau_data_t;

  // Instruction tag, returned with the result.
  typedef logic [TAG_W_DEF-1:0] fmau_tag_t;

  // Special class: multiplicand zero, multiplier zero.
  typedef logic [1:0] fmau_spec_t;

  // Instruction flags: mac, dst_double, simd.
  typedef logic [2:0] fmau_op_t;

  // Finish-slot reservation vector.
  // Bit i set means a result finishes i+1 cycles from now.
  typedef logic [LAT_EX5-1:0] fmau_slot_t;

  // One 32-bit lane.
  typedef logic [HALF_W-1:0] fmau_half_t;

endpackage

// ==== rtl/fmau_issue.sv ====
// Input side of the MAC unit: accepts instructions, carries the stage chain, reserves slots.
module fmau_issue #(
  parameter int unsigned TAG_W = 4
) (
  input  logic                 forever_cpuclk,
  input  logic                 arst_n,
  input  logic                 issue_vld,
  input  fmau_pkg::fmau_op_t   issue_op,
  input  logic [TAG_W-1:0]     issue_tag,
  input  fmau_pkg::fmau_data_t src_a,
  input  fmau_pkg::fmau_data_t src_b,
  input  fmau_pkg::fmau_data_t src_c,
  input  logic                 freeze,
  output logic                 issue_ready,
  output logic                 ex1_sel,
  output logic                 ex2_sel,
  output logic                 ex3_sel,
  output logic                 ex4_sel,
  output fmau_pkg::fmau_op_t   ex1_op,
  output fmau_pkg::fmau_op_t   ex2_op,
  output fmau_pkg::fmau_op_t   ex3_op,
  output fmau_pkg::fmau_op_t   ex4_op,
  output logic [TAG_W-1:0]     ex3_tag,
  output logic [TAG_W-1:0]     ex4_tag,
  output fmau_pkg::fmau_data_t ex1_src_a,
  output fmau_pkg::fmau_data_t ex1_src_b,
  output fmau_pkg::fmau_data_t ex1_src_c
);

  logic                 rdy_q;
  logic                 accept;
  logic                 a_zero;
  logic                 b_zero;
  logic                 is_special;
  logic                 is_fast;
  logic [2:0]           fin_dist;
  fmau_pkg::fmau_slot_t slot_q;
  fmau_pkg::fmau_slot_t slot_shift;
  logic                 collide;
  logic [TAG_W-1:0]     ex1_tag;
  logic [TAG_W-1:0]     ex2_tag;
  logic                 ex1_fast;
  logic                 ex2_fast;
  logic                 ex3_fast;

  // Zero operand check in the active width.
  assign a_zero = issue_op[fmau_pkg::OP_DBL] ? (src_a == '0)
                                              : (src_a[fmau_pkg::HALF_W-1:0] == '0);
  assign b_zero = issue_op[fmau_pkg::OP_DBL] ? (src_b == '0)
                                              : (src_b[fmau_pkg::HALF_W-1:0] == '0);
  // Simd never exits early.
  assign is_special = (a_zero || b_zero) && !issue_op[fmau_pkg::OP_SIMD];

  // Finishes in EX3.
  assign is_fast = is_special ||
                   (!issue_op[fmau_pkg::OP_MAC] && !issue_op[fmau_pkg::OP_DBL]);

  // Finish distance from EX1.
  always_comb begin
    if (is_fast) begin
      fin_dist = 3'(fmau_pkg::LAT_EX3);
    end else if (issue_op[fmau_pkg::OP_MAC] && issue_op[fmau_pkg::OP_DBL]) begin
      fin_dist = 3'(fmau_pkg::LAT_EX5);
    end else begin
      fin_dist = 3'(fmau_pkg::LAT_EX4);
    end
  end

  // Reservations one cycle on.
  assign slot_shift = slot_q >> 1;
  assign collide    = slot_shift[fin_dist-3'd1];

  assign issue_ready = rdy_q && !freeze && !collide;
  assign accept      = issue_vld && issue_ready;

  // Ready comes up one cycle after reset.
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  // Slot vector and stage valids.
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      slot_q  <= '0;
      ex1_sel <= 1'b0;
      ex2_sel <= 1'b0;
      ex3_sel <= 1'b0;
      ex4_sel <= 1'b0;
    end else if (!freeze) begin
      slot_q <= slot_shift;
      if (accept) begin
        slot_q[fin_dist-3'd1] <= 1'b1;
      end
      ex1_sel <= accept;
      ex2_sel <= ex1_sel;
      ex3_sel <= ex2_sel;
      // EX3 finishers leave the chain.
      ex4_sel <= ex3_sel && !ex3_fast;
    end
  end

  // Flags, tags and operands.
  always_ff @(posedge forever_cpuclk) begin
    if (!freeze) begin
      if (accept) begin
        ex1_op    <= issue_op;
        ex1_tag   <= issue_tag;
        ex1_fast  <= is_fast;
        ex1_src_a <= src_a;
        ex1_src_b <= src_b;
        ex1_src_c <= src_c;
      end
      ex2_op   <= ex1_op;
      ex2_tag  <= ex1_tag;
      ex2_fast <= ex1_fast;
      ex3_op   <= ex2_op;
      ex3_tag  <= ex2_tag;
      ex3_fast <= ex2_fast;
      ex4_op   <= ex3_op;
      ex4_tag  <= ex3_tag;
    end
  end

endmodule

// ==== rtl/fmau_ctrl.sv ====
// Stage controller of the MAC unit: per-stage advance and early-finish strobes.
module fmau_ctrl (
  input  logic                 ex1_sel,
  input  logic                 ex2_sel,
  input  logic                 ex3_sel,
  input  logic                 ex4_sel,
  input  fmau_pkg::fmau_op_t   ex2_op,
  input  fmau_pkg::fmau_op_t   ex3_op,
  input  fmau_pkg::fmau_op_t   ex4_op,
  input  fmau_pkg::fmau_spec_t ex2_spec,
  input  logic                 ex3_special_cmplt,
  input  logic                 freeze,
  output logic                 ex1_pipe_down,
  output logic                 ex2_pipe_down,
  output logic                 ex3_pipe_down,
  output logic                 ex4_pipe_down,
  output logic                 ex2_ready_in_ex3,
  output logic                 ex3_ready_in_ex4,
  output logic                 ex4_done_in_ex5
);

  logic ex3_continue;

  // EX1 and EX2 never finish.
  assign ex1_pipe_down = ex1_sel && !freeze;
  assign ex2_pipe_down = ex2_sel && !freeze;

  // Non-simd special or single multiply ends in EX3.
  assign ex2_ready_in_ex3 = ex2_sel &&
                            (((|ex2_spec) && !ex2_op[fmau_pkg::OP_SIMD]) ||
                             (!ex2_op[fmau_pkg::OP_MAC] && !ex2_op[fmau_pkg::OP_DBL]));

  // Goes on to EX4 unless already done.
  assign ex3_continue  = (ex3_op[fmau_pkg::OP_MAC] || ex3_op[fmau_pkg::OP_DBL]) &&
                         !ex3_special_cmplt;
  assign ex3_pipe_down = ex3_sel && ex3_continue && !freeze;

  // Exactly one of mac and double ends in EX4.
  assign ex3_ready_in_ex4 = ex3_sel && !ex3_special_cmplt &&
                            (ex3_op[fmau_pkg::OP_MAC] ^ ex3_op[fmau_pkg::OP_DBL]);

  // Double accumulate needs EX5.
  assign ex4_done_in_ex5 = ex4_sel && ex4_op[fmau_pkg::OP_MAC] && ex4_op[fmau_pkg::OP_DBL];
  assign ex4_pipe_down   = ex4_done_in_ex5 && !freeze;

endmodule

// ==== rtl/fmau_dp.sv ====
// Datapath of the MAC unit: zero detect, partial products, product assembly, accumulation.
module fmau_dp #(
  parameter int unsigned TAG_W = 4
) (
  input  logic                 forever_cpuclk,
  input  logic                 arst_n,
  input  fmau_pkg::fmau_data_t ex1_src_a,
  input  fmau_pkg::fmau_data_t ex1_src_b,
  input  fmau_pkg::fmau_data_t ex1_src_c,
  input  fmau_pkg::fmau_op_t   ex1_op,
  input  fmau_pkg::fmau_op_t   ex2_op,
  input  fmau_pkg::fmau_op_t   ex3_op,
  input  fmau_pkg::fmau_op_t   ex4_op,
  input  logic [TAG_W-1:0]     ex3_tag,
  input  logic [TAG_W-1:0]     ex4_tag,
  input  logic                 ex1_pipe_down,
  input  logic                 ex2_pipe_down,
  input  logic                 ex3_pipe_down,
  input  logic                 ex4_pipe_down,
  input  logic                 ex2_ready_in_ex3,
  output fmau_pkg::fmau_spec_t ex2_spec,
  output logic                 ex3_special_cmplt,
  output fmau_pkg::fmau_data_t ex3_result,
  output fmau_pkg::fmau_data_t ex4_result,
  output fmau_pkg::fmau_data_t ex5_result,
  output logic [TAG_W-1:0]     ex3_res_tag,
  output logic [TAG_W-1:0]     ex4_res_tag,
  output logic [TAG_W-1:0]     ex5_res_tag
);

  localparam int unsigned HW = fmau_pkg::HALF_W;

  fmau_pkg::fmau_spec_t ex1_spec;
  fmau_pkg::fmau_data_t ex2_a;
  fmau_pkg::fmau_data_t ex2_b;
  fmau_pkg::fmau_data_t ex2_c;
  fmau_pkg::fmau_data_t ex2_pp_ll;
  fmau_pkg::fmau_data_t ex2_pp_lh;
  fmau_pkg::fmau_data_t ex2_pp_hl;
  fmau_pkg::fmau_data_t ex2_pp_hh;
  fmau_pkg::fmau_data_t ex3_pp_ll;
  fmau_pkg::fmau_data_t ex3_pp_lh;
  fmau_pkg::fmau_data_t ex3_pp_hl;
  fmau_pkg::fmau_data_t ex3_pp_hh;
  fmau_pkg::fmau_data_t ex3_c;
  fmau_pkg::fmau_data_t ex3_prod;
  fmau_pkg::fmau_data_t ex3_addend;
  fmau_pkg::fmau_half_t ex3_cross;
  fmau_pkg::fmau_data_t ex4_prod;
  fmau_pkg::fmau_data_t ex4_pp_ll;
  fmau_pkg::fmau_half_t ex4_cross;
  fmau_pkg::fmau_data_t ex4_c;
  fmau_pkg::fmau_data_t ex4_dprod;
  fmau_pkg::fmau_data_t ex5_prod;
  fmau_pkg::fmau_data_t ex5_c;

  // EX1: zero operand detect in the active width.
  assign ex1_spec[fmau_pkg::SPEC_A_ZERO] = ex1_op[fmau_pkg::OP_DBL] ? (ex1_src_a == '0)
                                                                     : (ex1_src_a[HW-1:0] == '0);
  assign ex1_spec[fmau_pkg::SPEC_B_ZERO] = ex1_op[fmau_pkg::OP_DBL] ? (ex1_src_b == '0)
                                                                     : (ex1_src_b[HW-1:0] == '0);

  // Special class is control state.
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      ex2_spec          <= '0;
      ex3_special_cmplt <= 1'b0;
    end else begin
      if (ex1_pipe_down) begin
        ex2_spec <= ex1_spec;
      end
      if (ex2_pipe_down) begin
        // Early exit only for non-simd specials.
        ex3_special_cmplt <= ex2_ready_in_ex3 && (|ex2_spec) && !ex2_op[fmau_pkg::OP_SIMD];
      end
    end
  end

  // EX2: four 32x32 partial products.
  assign ex2_pp_ll = ex2_a[HW-1:0]  * ex2_b[HW-1:0];
  assign ex2_pp_lh = ex2_a[HW-1:0]  * ex2_b[2*HW-1:HW];
  assign ex2_pp_hl = ex2_a[2*HW-1:HW] * ex2_b[HW-1:0];
  assign ex2_pp_hh = ex2_a[2*HW-1:HW] * ex2_b[2*HW-1:HW];

  // EX3: lane products, or the special result.
  assign ex3_prod   = ex3_op[fmau_pkg::OP_SIMD] ? {ex3_pp_hh[HW-1:0], ex3_pp_ll[HW-1:0]}
                                                 : {{HW{1'b0}}, ex3_pp_ll[HW-1:0]};
  assign ex3_addend = ex3_op[fmau_pkg::OP_DBL] ? ex3_c : {{HW{1'b0}}, ex3_c[HW-1:0]};
  assign ex3_cross  = ex3_pp_lh[HW-1:0] + ex3_pp_hl[HW-1:0];

  always_comb begin
    if (ex3_special_cmplt) begin
      // Zero product leaves the addend.
      ex3_result = ex3_op[fmau_pkg::OP_MAC] ? ex3_addend : '0;
    end else begin
      ex3_result = ex3_prod;
    end
  end
  assign ex3_res_tag = ex3_tag;

  // EX4: double product, or single accumulate per lane.
  assign ex4_dprod = ex4_pp_ll + {ex4_cross, {HW{1'b0}}};

  always_comb begin
    if (ex4_op[fmau_pkg::OP_DBL]) begin
      ex4_result = ex4_dprod;
    end else if (ex4_op[fmau_pkg::OP_SIMD]) begin
      ex4_result = {ex4_prod[2*HW-1:HW] + ex4_c[2*HW-1:HW], ex4_prod[HW-1:0] + ex4_c[HW-1:0]};
    end else begin
      ex4_result = {{HW{1'b0}}, ex4_prod[HW-1:0] + ex4_c[HW-1:0]};
    end
  end
  assign ex4_res_tag = ex4_tag;

  // EX5: double accumulate.
  assign ex5_result = ex5_prod + ex5_c;

  // Stage payload registers.
  always_ff @(posedge forever_cpuclk) begin
    if (ex1_pipe_down) begin
      ex2_a <= ex1_src_a;
      ex2_b <= ex1_src_b;
      ex2_c <= ex1_src_c;
    end
    if (ex2_pipe_down) begin
      ex3_pp_ll <= ex2_pp_ll;
      ex3_pp_lh <= ex2_pp_lh;
      ex3_pp_hl <= ex2_pp_hl;
      ex3_pp_hh <= ex2_pp_hh;
      ex3_c     <= ex2_c;
    end
    if (ex3_pipe_down) begin
      ex4_prod  <= ex3_prod;
      ex4_pp_ll <= ex3_pp_ll;
      ex4_cross <= ex3_cross;
      ex4_c     <= ex3_c;
    end
    if (ex4_pipe_down) begin
      ex5_prod    <= ex4_dprod;
      ex5_c       <= ex4_c;
      ex5_res_tag <= ex4_tag;
    end
  end

endmodule

// ==== rtl/fmau_retire.sv ====
// Output side of the MAC unit: picks the finishing stage and holds the result register.
module fmau_retire #(
  parameter int unsigned TAG_W = 4
) (
  input  logic                 forever_cpuclk,
  input  logic                 arst_n,
  input  logic                 wb_stall,
  input  logic                 ex2_ready_in_ex3,
  input  logic                 ex3_ready_in_ex4,
  input  logic                 ex4_done_in_ex5,
  input  fmau_pkg::fmau_data_t ex3_result,
  input  fmau_pkg::fmau_data_t ex4_result,
  input  fmau_pkg::fmau_data_t ex5_result,
  input  logic [TAG_W-1:0]     ex3_tag,
  input  logic [TAG_W-1:0]     ex4_tag,
  input  logic [TAG_W-1:0]     ex5_tag,
  output logic                 res_vld,
  output fmau_pkg::fmau_data_t res_data,
  output logic [TAG_W-1:0]     res_tag,
  output logic                 freeze
);

  logic                 fin3_q;
  logic                 fin4_q;
  logic                 fin5_q;
  logic                 hold_vld;
  fmau_pkg::fmau_data_t hold_data;
  logic [TAG_W-1:0]     hold_tag;

  // Full output register under stall holds the whole unit.
  assign freeze = res_vld && wb_stall;

  // Which stage finishes this cycle, then the captured result.
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      fin3_q   <= 1'b0;
      fin4_q   <= 1'b0;
      fin5_q   <= 1'b0;
      hold_vld <= 1'b0;
      res_vld  <= 1'b0;
    end else if (!freeze) begin
      fin3_q   <= ex2_ready_in_ex3;
      fin4_q   <= ex3_ready_in_ex4;
      fin5_q   <= ex4_done_in_ex5;
      hold_vld <= fin3_q || fin4_q || fin5_q;
      res_vld  <= hold_vld;
    end
  end

  // Slots keep at most one finisher per cycle.
  always_ff @(posedge forever_cpuclk) begin
    if (!freeze) begin
      if (fin5_q) begin
        hold_data <= ex5_result;
        hold_tag  <= ex5_tag;
      end else if (fin4_q) begin
        hold_data <= ex4_result;
        hold_tag  <= ex4_tag;
      end else if (fin3_q) begin
        hold_data <= ex3_result;
        hold_tag  <= ex3_tag;
      end
      if (hold_vld) begin
        res_data <= hold_data;
        res_tag  <= hold_tag;
      end
    end
  end

endmodule

// ==== rtl/fmau_top.sv ====
// Top level of the MAC unit: connects issue, stage control, datapath and retire.
module fmau_top #(
  parameter int unsigned TAG_W = 4
) (
  input  logic                 forever_cpuclk,
  input  logic                 arst_n,
  input  logic                 issue_vld,
  input  fmau_pkg::fmau_op_t   issue_op,
  input  logic [TAG_W-1:0]     issue_tag,
  input  fmau_pkg::fmau_data_t src_a,
  input  fmau_pkg::fmau_data_t src_b,
  input  fmau_pkg::fmau_data_t src_c,
  input  logic                 wb_stall,
  output logic                 issue_ready,
  output logic                 res_vld,
  output fmau_pkg::fmau_data_t res_data,
  output logic [TAG_W-1:0]     res_tag
);

  logic                 freeze;
  logic                 ex1_sel, ex2_sel, ex3_sel, ex4_sel;
  fmau_pkg::fmau_op_t   ex1_op, ex2_op, ex3_op, ex4_op;
  logic [TAG_W-1:0]     ex3_tag, ex4_tag;
  fmau_pkg::fmau_data_t ex1_src_a, ex1_src_b, ex1_src_c;
  fmau_pkg::fmau_spec_t ex2_spec;
  logic                 ex3_special_cmplt;
  logic                 ex1_pipe_down, ex2_pipe_down, ex3_pipe_down, ex4_pipe_down;
  logic                 ex2_ready_in_ex3, ex3_ready_in_ex4, ex4_done_in_ex5;
  fmau_pkg::fmau_data_t ex3_result, ex4_result, ex5_result;
  logic [TAG_W-1:0]     ex3_res_tag, ex4_res_tag, ex5_res_tag;

  fmau_issue #(.TAG_W(TAG_W)) u_issue (
    .forever_cpuclk, .arst_n, .issue_vld, .issue_op, .issue_tag,
    .src_a, .src_b, .src_c, .freeze, .issue_ready,
    .ex1_sel, .ex2_sel, .ex3_sel, .ex4_sel,
    .ex1_op, .ex2_op, .ex3_op, .ex4_op, .ex3_tag, .ex4_tag,
    .ex1_src_a, .ex1_src_b, .ex1_src_c
  );

  fmau_ctrl u_ctrl (
    .ex1_sel, .ex2_sel, .ex3_sel, .ex4_sel, .ex2_op, .ex3_op, .ex4_op,
    .ex2_spec, .ex3_special_cmplt, .freeze,
    .ex1_pipe_down, .ex2_pipe_down, .ex3_pipe_down, .ex4_pipe_down,
    .ex2_ready_in_ex3, .ex3_ready_in_ex4, .ex4_done_in_ex5
  );

  fmau_dp #(.TAG_W(TAG_W)) u_dp (
    .forever_cpuclk, .arst_n, .ex1_src_a, .ex1_src_b, .ex1_src_c,
    .ex1_op, .ex2_op, .ex3_op, .ex4_op, .ex3_tag, .ex4_tag,
    .ex1_pipe_down, .ex2_pipe_down, .ex3_pipe_down, .ex4_pipe_down,
    .ex2_ready_in_ex3, .ex2_spec, .ex3_special_cmplt,
    .ex3_result, .ex4_result, .ex5_result, .ex3_res_tag, .ex4_res_tag, .ex5_res_tag
  );

  // Result tags from the datapath feed the output register.
  fmau_retire #(.TAG_W(TAG_W)) u_retire (
    .forever_cpuclk, .arst_n, .wb_stall,
    .ex2_ready_in_ex3, .ex3_ready_in_ex4, .ex4_done_in_ex5,
    .ex3_result, .ex4_result, .ex5_result,
    .ex3_tag(ex3_res_tag), .ex4_tag(ex4_res_tag), .ex5_tag(ex5_res_tag),
    .res_vld, .res_data, .res_tag, .freeze
  );

endmodule

// ==== tb/fmau_tb.sv ====
// Self-checking testbench for the MAC unit; drives random and directed instructions, checks a model.
module fmau_tb;

  localparam int unsigned TAG_W    = 4;
  localparam int          NTAG     = 1 << TAG_W;
  localparam int          ISSUE_TO = 60;
  localparam int          DRAIN_TO = 400;

  logic                 forever_cpuclk;
  logic                 arst_n;
  logic                 issue_vld;
  fmau_pkg::fmau_op_t   issue_op;
  logic [TAG_W-1:0]     issue_tag;
  fmau_pkg::fmau_data_t src_a;
  fmau_pkg::fmau_data_t src_b;
  fmau_pkg::fmau_data_t src_c;
  logic                 wb_stall = 1'b0;
  logic                 issue_ready;
  logic                 res_vld;
  fmau_pkg::fmau_data_t res_data;
  logic [TAG_W-1:0]     res_tag;

  // One scoreboard entry per tag.
  logic                 pend [NTAG];
  fmau_pkg::fmau_data_t exp_data [NTAG];
  int                   exp_edge [NTAG];

  int                   cyc = 0;
  int                   errors = 0;
  int                   tests = 0;
  int                   tests_failed = 0;
  int                   delivered = 0;
  int                   freeze_cycles = 0;
  int                   seed_val;
  logic                 prev_freeze = 1'b0;
  logic                 stall_en = 1'b0;
  int                   stall_left = 0;
  logic [TAG_W-1:0]     next_tag = '0;
  fmau_pkg::fmau_data_t last_data;
  logic [TAG_W-1:0]     last_tag;

  fmau_top #(.TAG_W(TAG_W)) dut0 (
    .forever_cpuclk, .arst_n, .issue_vld, .issue_op, .issue_tag,
    .src_a, .src_b, .src_c, .wb_stall,
    .issue_ready, .res_vld, .res_data, .res_tag
  );

  always #50 forever_cpuclk = ~forever_cpuclk;

  // Counts rising edges.
  always @(posedge forever_cpuclk) begin
    cyc <= cyc + 1;
  end

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at time %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic timeout_abort(input string msg);
    $display("Timeout at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $finish;
  endtask

  // Wrap-around integer result; single width works on 32-bit lanes.
  function automatic fmau_pkg::fmau_data_t model_result(input fmau_pkg::fmau_op_t op,
      input fmau_pkg::fmau_data_t a, input fmau_pkg::fmau_data_t b,
      input fmau_pkg::fmau_data_t c);
    fmau_pkg::fmau_data_t full;
    fmau_pkg::fmau_half_t lo;
    fmau_pkg::fmau_half_t hi;
    if (op[fmau_pkg::OP_DBL]) begin
      full = a * b;
      if (op[fmau_pkg::OP_MAC]) begin
        full = full + c;
      end
      return full;
    end
    lo = a[31:0] * b[31:0];
    hi = a[63:32] * b[63:32];
    if (op[fmau_pkg::OP_MAC]) begin
      lo = lo + c[31:0];
      hi = hi + c[63:32];
    end
    return op[fmau_pkg::OP_SIMD] ? {hi, lo} : {32'h0, lo};
  endfunction

  // Cycles from the accepting edge to res_vld; one more than the finish slot.
  function automatic int model_latency(input fmau_pkg::fmau_op_t op,
      input fmau_pkg::fmau_data_t a, input fmau_pkg::fmau_data_t b);
    logic zero_in;
    zero_in = op[fmau_pkg::OP_DBL] ? (a == '0 || b == '0) : (a[31:0] == '0 || b[31:0] == '0);
    if ((zero_in && !op[fmau_pkg::OP_SIMD]) ||
        (!op[fmau_pkg::OP_MAC] && !op[fmau_pkg::OP_DBL])) begin
      return fmau_pkg::LAT_EX3 + 1;
    end
    if (op[fmau_pkg::OP_MAC] && op[fmau_pkg::OP_DBL]) begin
      return fmau_pkg::LAT_EX5 + 1;
    end
    return fmau_pkg::LAT_EX4 + 1;
  endfunction

  function automatic logic any_pending();
    for (int t = 0; t < NTAG; t++) begin
      if (pend[t]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic record_issue();
    int t;
    t = int'(issue_tag);
    assert (!pend[t]) else report_failure($sformatf("tag %0d issued while in flight", t));
    pend[t]     = 1'b1;
    exp_data[t] = model_result(issue_op, src_a, src_b, src_c);
    exp_edge[t] = cyc + 1 + model_latency(issue_op, src_a, src_b);
  endtask

  // Fresh result in the output register.
  task automatic check_result();
    int t;
    t = int'(res_tag);
    assert (pend[t]) else report_failure($sformatf("result for tag %0d not in flight", t));
    if (pend[t]) begin
      assert (res_data == exp_data[t]) else value_error("res_data", exp_data[t], res_data);
      assert (cyc == exp_edge[t]) else value_error("res_vld cycle", 64'(exp_edge[t]), 64'(cyc));
      pend[t] = 1'b0;
      delivered++;
    end
  endtask

  // Output register under freeze.
  task automatic check_hold();
    assert (res_vld) else report_failure("res_vld dropped while stalled");
    assert (res_data == last_data) else value_error("res_data", last_data, res_data);
    assert (res_tag == last_tag) else value_error("res_tag", 64'(last_tag), 64'(res_tag));
  endtask

  // Issue stays closed while the output register is stalled.
  assert property (@(negedge forever_cpuclk) disable iff (!arst_n)
                   (res_vld && wb_stall) |-> !issue_ready)
    else report_failure("issue_ready was high while the result register was stalled");

  // Samples at the falling edge, where every output is settled.
  always @(negedge forever_cpuclk) begin : monitor
    logic frz;
    frz = res_vld && wb_stall;
    if (!arst_n) begin
      for (int t = 0; t < NTAG; t++) begin
        pend[t] = 1'b0;
      end
      prev_freeze = 1'b0;
    end else begin
      if (res_vld && !prev_freeze) begin
        check_result();
      end
      if (prev_freeze) begin
        check_hold();
      end
      for (int t = 0; t < NTAG; t++) begin
        if (pend[t] && exp_edge[t] < cyc) begin
          report_failure($sformatf("result for tag %0d missing at its expected cycle", t));
          pend[t] = 1'b0;
        end
        // A frozen edge delays all in flight.
        if (frz && pend[t] && exp_edge[t] > cyc) begin
          exp_edge[t] = exp_edge[t] + 1;
        end
      end
      if (frz) begin
        freeze_cycles++;
      end
      if (issue_vld && issue_ready) begin
        record_issue();
      end
      last_data   = res_data;
      last_tag    = res_tag;
      prev_freeze = frz;
    end
  end

  // Write-back stall bursts of random length.
  always @(posedge forever_cpuclk) begin
    #5;
    if (!stall_en) begin
      wb_stall   = 1'b0;
      stall_left = 0;
    end else if (stall_left == 0) begin
      wb_stall   = 1'($urandom % 2);
      stall_left = 1 + int'($urandom % 6);
    end else begin
      stall_left--;
    end
  end

  function automatic fmau_pkg::fmau_data_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // Called at posedge plus 5; returns there after the accepting edge.
  task automatic issue_instr(input fmau_pkg::fmau_op_t op, input fmau_pkg::fmau_data_t a,
                             input fmau_pkg::fmau_data_t b, input fmau_pkg::fmau_data_t c,
                             output int held);
    int   n;
    logic taken;
    n     = 0;
    taken = 1'b0;
    held  = 0;
    while (pend[next_tag]) begin
      @(posedge forever_cpuclk);
      #5;
      n++;
      if (n > DRAIN_TO) timeout_abort("tag never came back from the unit");
    end
    n         = 0;
    issue_vld = 1'b1;
    issue_op  = op;
    issue_tag = next_tag;
    src_a     = a;
    src_b     = b;
    src_c     = c;
    while (!taken) begin
      @(negedge forever_cpuclk);
      if (issue_ready) begin
        taken = 1'b1;
      end else begin
        held++;
      end
      n++;
      if (n > ISSUE_TO) timeout_abort("issue_ready stayed low, instruction never accepted");
      @(posedge forever_cpuclk);
      #5;
    end
    issue_vld = 1'b0;
    next_tag  = next_tag + 1'b1;
  endtask

  task automatic issue_random();
    fmau_pkg::fmau_data_t a;
    fmau_pkg::fmau_data_t b;
    int                   held;
    a = rand_word();
    b = rand_word();
    if ($urandom % 6 == 0) begin
      a = '0;
    end
    if ($urandom % 6 == 0) begin
      b[31:0] = '0;
    end
    issue_instr(3'($urandom % 8), a, b, rand_word(), held);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (any_pending() || (res_vld && wb_stall)) begin
      @(posedge forever_cpuclk);
      #5;
      n++;
      if (n > DRAIN_TO) timeout_abort("results still missing after the drain limit");
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  initial begin
    int e;
    int held;
    int frz0;
    fmau_pkg::fmau_data_t nz;
    seed_val       = $urandom(63180);
    forever_cpuclk = 1'b0;
    arst_n         = 1'b0;
    issue_vld      = 1'b0;
    issue_op       = '0;
    issue_tag      = '0;
    src_a          = '0;
    src_b          = '0;
    src_c          = '0;
    repeat (2) @(posedge forever_cpuclk);
    #5 arst_n = 1'b1;

    // Reset state.
    e    = errors;
    held = 0;
    @(negedge forever_cpuclk);
    assert (!res_vld) else report_failure("res_vld high after reset");
    while (!issue_ready && held < 1) begin
      @(negedge forever_cpuclk);
      held++;
    end
    assert (issue_ready) else report_failure("issue_ready did not rise after reset release");
    @(posedge forever_cpuclk);
    #5;
    end_test("reset_state", e);

    // Every flag combination with nonzero lanes.
    e = errors;
    for (int i = 0; i < 32; i++) begin
      issue_instr(3'(i % 8), rand_word() | 64'h1_0000_0001, rand_word() | 64'h1_0000_0001,
                  rand_word(), held);
    end
    drain();
    end_test("arithmetic", e);

    // Zero operands and simd lanes that must not exit early.
    e  = errors;
    nz = rand_word() | 64'h1_0000_0001;
    issue_instr(3'b100, '0, nz, rand_word(), held);
    issue_instr(3'b100, nz, {32'h5, 32'h0}, rand_word(), held);
    issue_instr(3'b110, nz, '0, rand_word(), held);
    issue_instr(3'b010, '0, nz, rand_word(), held);
    issue_instr(3'b101, {32'h7, 32'h0}, nz, rand_word(), held);
    issue_instr(3'b111, '0, nz, rand_word(), held);
    issue_instr(3'b110, {32'h3, 32'h0}, nz, rand_word(), held);
    drain();
    end_test("early_exit", e);

    // One instruction per class alone in the pipe.
    e = errors;
    issue_instr(3'b000, nz, nz, rand_word(), held);
    drain();
    issue_instr(3'b100, nz, nz, rand_word(), held);
    drain();
    issue_instr(3'b010, nz, nz, rand_word(), held);
    drain();
    issue_instr(3'b110, nz, nz, rand_word(), held);
    drain();
    end_test("latency_classes", e);

    // Random traffic under write-back stall.
    e        = errors;
    frz0     = freeze_cycles;
    stall_en = 1'b1;
    for (int i = 0; i < 60; i++) begin
      issue_random();
    end
    stall_en = 1'b0;
    drain();
    assert (freeze_cycles > frz0) else report_failure("no freeze seen during stall traffic");
    end_test("back_pressure", e);

    // Colliding finish slots must be held off.
    e = errors;
    issue_instr(3'b110, nz, nz, rand_word(), held);
    issue_instr(3'b100, nz, nz, rand_word(), held);
    assert (held > 0) else report_failure("EX4 issue after EX5 was not held off");
    drain();
    issue_instr(3'b100, nz, nz, rand_word(), held);
    issue_instr(3'b000, nz, nz, rand_word(), held);
    assert (held > 0) else report_failure("EX3 issue after EX4 was not held off");
    for (int i = 0; i < 40; i++) begin
      issue_random();
    end
    drain();
    end_test("slot_conflicts", e);

    $display("tests %0d, failed %0d, check errors %0d, results %0d",
             tests, tests_failed, errors, delivered);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/fmau_pkg.sv
rtl/fmau_issue.sv
rtl/fmau_ctrl.sv
rtl/fmau_dp.sv
rtl/fmau_retire.sv
rtl/fmau_top.sv
tb/fmau_tb.sv

// ==== Makefile ====
# Verilator build and run for the MAC unit testbench.
VERILATOR ?= verilator
TOP       ?= fmau_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 63180
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat build.f)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): build.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f

# The run passes only if the log holds the pass line.
run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
